// File: flist.f
+incdir+.
dbg_pkg.sv
dbg_rx_stage.sv
dbg_program_loader.sv
dbg_run_control.sv
dbg_bucket_sender.sv
debug_unit.sv
debug_unit_assertions.sv
tb_debug_unit.sv

// File: Bender.yml
package:
  name: debug_unit

export_include_dirs:
  - .

sources:
  - files:
      - dbg_pkg.sv
      - dbg_rx_stage.sv
      - dbg_program_loader.sv
      - dbg_run_control.sv
      - dbg_bucket_sender.sv
      - debug_unit.sv
  - target: test
    files:
      - debug_unit_assertions.sv
      - tb_debug_unit.sv

// File: tb_debug_unit.sv
`include "dbg_params.svh"

module tb_debug_unit;

  localparam int drive_dly  = 2;
  localparam int wait_limit = 400;  // cycles per wait loop

  logic                  clk;
  logic                  reset;
  logic                  halt;
  dbg_pkg::bucket_t      bucket;
  logic                  rx_done_tick;
  dbg_pkg::byte_t        rx_data;
  logic                  tx_done_tick;
  logic                  inst_we;
  dbg_pkg::inst_addr_t   inst_addr;
  dbg_pkg::inst_word_t   inst_data;
  logic                  programming;
  logic                  cpu_clk_en;
  dbg_pkg::cycle_count_t cycle_count;
  logic                  tx_start;
  dbg_pkg::byte_t        tx_data;

  logic [31:0]    lfsr_state = 32'hf1c9_3e11;
  logic [31:0]    wr_addr[$];  // observed instruction writes
  logic [31:0]    wr_data[$];
  dbg_pkg::byte_t tx_bytes[$];  // bytes taken by the uart model
  int             clk_en_cycles;

  debug_unit i_debug_unit (.*);

  always #20 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // monitors and uart transmitter model
  //////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (inst_we)
    begin
      wr_addr.push_back(inst_addr);
      wr_data.push_back(inst_data);
    end
    if (cpu_clk_en)
      clk_en_cycles++;
  end

  always
  begin
    @(posedge clk);
    #drive_dly;
    if (tx_start === 1'b1)
    begin
      repeat (3) @(posedge clk);  // byte time on the wire
      #drive_dly;
      tx_bytes.push_back(tx_data);
      tx_done_tick = 1'b1;
      @(posedge clk);
      #drive_dly;
      tx_done_tick = 1'b0;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic set_inputs(input logic h, input dbg_pkg::bucket_t b);
    @(posedge clk);
    #drive_dly;
    halt   = h;
    bucket = b;
  endtask

  // one receive-done pulse, then three idle cycles
  task automatic send_byte(input dbg_pkg::byte_t b);
    @(posedge clk);
    #drive_dly;
    rx_data      = b;
    rx_done_tick = 1'b1;
    @(posedge clk);
    #drive_dly;
    rx_done_tick = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_send_end();
    int n;
    n = 0;
    while (tx_bytes.size() < `DBG_BUCKET_BYTES || tx_start)
    begin
      @(negedge clk);
      n++;
      if (n > wait_limit)
        report_timeout("the bucket snapshot to be sent");
    end
  endtask

  task automatic check_tx_bytes(input string name, input dbg_pkg::bucket_t b);
    check({name, " byte count"}, `DBG_BUCKET_BYTES, tx_bytes.size());
    for (int k = 0; k < `DBG_BUCKET_BYTES; k++)
      check(name, b[8*k +: 8], tx_bytes[k]);  // lsb first
  endtask

  task automatic load_program(input string name, input int n_words);
    logic [31:0] words[$];
    logic [31:0] w;
    int          n;
    wr_addr.delete();
    wr_data.delete();
    for (int i = 0; i < n_words; i++)
    begin
      w = rand_bits(32);
      if (i == n_words - 1)
        w[31 -: `DBG_END_OPCODE_W] = '1;  // end marker
      else
        w[31] = 1'b0;  // not an end word
      words.push_back(w);
    end
    send_byte(`DBG_CMD_START);
    check({name, " programming high"}, 1, programming);
    foreach (words[i])
      for (int k = 0; k < 4; k++)
        send_byte(words[i][8*k +: 8]);
    n = 0;
    while (programming)
    begin
      @(negedge clk);
      n++;
      if (n > wait_limit)
        report_timeout("programming to end");
    end
    check({name, " write count"}, n_words, wr_addr.size());
    foreach (words[i])
    begin
      check({name, " address"}, i, wr_addr[i]);
      check({name, " data"}, words[i], wr_data[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check("test_reset inst_we", 0, inst_we);
    check("test_reset cpu_clk_en", 0, cpu_clk_en);
    check("test_reset tx_start", 0, tx_start);
    check("test_reset programming", 0, programming);
    check("test_reset cycle_count", 0, cycle_count);
  endtask

  task automatic test_program();
    load_program("test_program", 3);
  endtask

  task automatic test_step();
    dbg_pkg::bucket_t b;
    b = rand_bits(32);
    set_inputs(1'b0, b);
    send_byte(`DBG_CMD_STEP_MODE);
    clk_en_cycles = 0;
    tx_bytes.delete();
    send_byte(`DBG_CMD_STEP);
    wait_send_end();
    check("test_step clock cycles", 1, clk_en_cycles);
    check("test_step cycle_count", 1, cycle_count);
    check_tx_bytes("test_step bytes", b);
    // second step with halt high returns to waiting
    b = rand_bits(32);
    set_inputs(1'b1, b);
    clk_en_cycles = 0;
    tx_bytes.delete();
    send_byte(`DBG_CMD_STEP);
    wait_send_end();
    check("test_step halted clock cycles", 1, clk_en_cycles);
    check("test_step halted cycle_count", 2, cycle_count);
    check_tx_bytes("test_step halted bytes", b);
    clk_en_cycles = 0;
    send_byte(`DBG_CMD_STEP);
    check("test_step waiting clock cycles", 0, clk_en_cycles);
    check("test_step waiting tx_start", 0, tx_start);
  endtask

  task automatic test_continuous();
    dbg_pkg::bucket_t b;
    int               run_len;
    int               run_cycles;
    load_program("test_continuous", 2);
    b          = rand_bits(32);
    run_len    = rand_bits(5) + 4;
    run_cycles = run_len + 2;  // two enabled cycles pass inside send_byte
    set_inputs(1'b0, b);
    clk_en_cycles = 0;
    tx_bytes.delete();
    send_byte(`DBG_CMD_CONTINUOUS);
    repeat (run_len) @(negedge clk);
    set_inputs(1'b1, b);
    set_inputs(1'b1, ~b);  // snapshot already taken on the halt edge
    wait_send_end();
    check("test_continuous clock cycles", run_cycles, clk_en_cycles);
    check("test_continuous cycle_count", run_cycles, cycle_count);
    check_tx_bytes("test_continuous bytes", b);
  endtask

  task automatic test_reprogram();
    dbg_pkg::byte_t stray;
    send_byte(`DBG_CMD_REPROGRAM);
    wr_addr.delete();
    // enough stray bytes for a whole word
    for (int i = 0; i < 4; i++)
    begin
      stray = 8'(rand_bits(8)) | 8'h80;  // never the start code
      send_byte(stray);
    end
    check("test_reprogram stray writes", 0, wr_addr.size());
    check("test_reprogram programming", 0, programming);
    load_program("test_reprogram", 1);
  endtask

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    halt         = 1'b0;
    bucket       = '0;
    rx_done_tick = 1'b0;
    rx_data      = '0;
    tx_done_tick = 1'b0;
    repeat (16) @(posedge clk);
    #drive_dly;
    reset = 1'b0;
    @(negedge clk);
    test_reset();
    test_program();
    test_step();
    test_continuous();
    test_reprogram();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: debug_unit_assertions.sv
module debug_unit_assertions (
  input logic clk,
  input logic reset,
  input logic inst_we,
  input logic programming,
  input logic cpu_clk_en,
  input logic tx_start
);

  // one write per assembled word
  a_we_single: assert property (@(posedge clk) disable iff (reset)
    inst_we |=> !inst_we)
    else $error("inst_we high for two cycles in a row");

  a_we_programming: assert property (@(posedge clk) disable iff (reset)
    inst_we |-> programming)
    else $error("instruction write outside programming");

  // processor stays frozen while a snapshot goes out
  a_clk_en_tx: assert property (@(posedge clk) disable iff (reset)
    !(cpu_clk_en && tx_start))
    else $error("cpu_clk_en high during a transfer");

endmodule

bind debug_unit debug_unit_assertions i_assertions (
  .clk, .reset, .inst_we, .programming, .cpu_clk_en, .tx_start
);

// File: debug_unit.sv
module debug_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  halt,
  input  dbg_pkg::bucket_t      bucket,
  input  logic                  rx_done_tick,
  input  dbg_pkg::byte_t        rx_data,
  input  logic                  tx_done_tick,
  output logic                  inst_we,
  output dbg_pkg::inst_addr_t   inst_addr,
  output dbg_pkg::inst_word_t   inst_data,
  output logic                  programming,
  output logic                  cpu_clk_en,
  output dbg_pkg::cycle_count_t cycle_count,
  output logic                  tx_start,
  output dbg_pkg::byte_t        tx_data
);

  logic           byte_valid;  // received byte strobe
  dbg_pkg::byte_t byte_data;
  logic           load_en;
  logic           load_done;
  logic           send_start;
  logic           send_done;

  dbg_rx_stage i_rx_stage (
    .clk, .reset, .rx_done_tick, .rx_data,
    .byte_valid, .byte_data
  );

  dbg_run_control i_run_control (
    .clk, .reset, .byte_valid, .byte_data,
    .halt, .load_done, .send_done,
    .load_en, .programming, .send_start,
    .cpu_clk_en, .cycle_count
  );

  dbg_program_loader i_program_loader (
    .clk, .reset, .load_en, .byte_valid, .byte_data,
    .inst_we, .inst_addr, .inst_data, .load_done
  );

  // snapshot goes out after each step or halt
  dbg_bucket_sender i_bucket_sender (
    .clk, .reset, .send_start, .bucket, .tx_done_tick,
    .tx_start, .tx_data, .send_done
  );

endmodule

// File: dbg_bucket_sender.sv
`include "dbg_params.svh"

module dbg_bucket_sender (
  input  logic             clk,
  input  logic             reset,
  input  logic             send_start,
  input  dbg_pkg::bucket_t bucket,
  input  logic             tx_done_tick,
  output logic             tx_start,
  output dbg_pkg::byte_t   tx_data,
  output logic             send_done
);

  localparam int idx_w = $clog2(`DBG_BUCKET_BYTES);
  localparam logic [idx_w-1:0] last_idx = idx_w'(`DBG_BUCKET_BYTES - 1);

  dbg_pkg::bucket_t snap_q;     // bucket frozen at send_start
  logic [idx_w-1:0] idx_q;      // byte being transmitted
  logic             tx_done_q;
  logic             tx_rise;

  assign tx_rise = tx_done_tick & ~tx_done_q;
  assign tx_data = snap_q[idx_q*`DBG_BYTE_W +: `DBG_BYTE_W];  // lsb first

  always_ff @(posedge clk)
  begin
    if (send_start)
      snap_q <= bucket;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_done_q <= 1'b0;
      tx_start  <= 1'b0;
      idx_q     <= '0;
      send_done <= 1'b0;
    end
    else
    begin
      tx_done_q <= tx_done_tick;
      send_done <= 1'b0;
      if (send_start)
      begin
        tx_start <= 1'b1;  // held for the whole transfer
        idx_q    <= '0;
      end
      else if (tx_start && tx_rise)
      begin
        if (idx_q == last_idx)
        begin
          tx_start  <= 1'b0;
          send_done <= 1'b1;
        end
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

// File: dbg_run_control.sv
module dbg_run_control (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  byte_valid,
  input  dbg_pkg::byte_t        byte_data,
  input  logic                  halt,
  input  logic                  load_done,
  input  logic                  send_done,
  output logic                  load_en,
  output logic                  programming,
  output logic                  send_start,
  output logic                  cpu_clk_en,
  output dbg_pkg::cycle_count_t cycle_count
);

  dbg_pkg::dbg_state_e   state;
  dbg_pkg::dbg_state_e   state_next;
  dbg_pkg::dbg_cmd_e     cmd;
  dbg_pkg::cycle_count_t cycle_q;
  logic                  step_hit;     // step command seen in step state
  logic                  step_fire_q;  // snapshot request one cycle after a step
  logic                  run_cont;

  assign cmd      = dbg_pkg::dbg_cmd_e'(byte_data);
  assign step_hit = (state == dbg_pkg::st_step) && byte_valid &&
                    (cmd == dbg_pkg::cmd_step);
  assign run_cont = (state == dbg_pkg::st_continuous);

  assign load_en     = (state == dbg_pkg::st_programming);
  assign programming = load_en;
  assign cpu_clk_en  = step_hit || (run_cont && !halt);
  assign send_start  = step_fire_q || (run_cont && halt);  // halt ends the run
  assign cycle_count = cycle_q;

  //////////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      dbg_pkg::st_idle:
        if (byte_valid && (cmd == dbg_pkg::cmd_start))
          state_next = dbg_pkg::st_programming;
      dbg_pkg::st_programming:
        if (load_done)
          state_next = dbg_pkg::st_waiting;
      dbg_pkg::st_waiting:
        if (byte_valid)
        begin
          case (cmd)
            dbg_pkg::cmd_continuous: state_next = dbg_pkg::st_continuous;
            dbg_pkg::cmd_step_mode:  state_next = dbg_pkg::st_step;
            default:                 state_next = dbg_pkg::st_idle;  // reprogram too
          endcase
        end
      dbg_pkg::st_step:
        if (step_hit)
          state_next = dbg_pkg::st_sending;
      dbg_pkg::st_continuous:
        if (halt)
          state_next = dbg_pkg::st_sending;
      dbg_pkg::st_sending:
        if (send_done)
          state_next = halt ? dbg_pkg::st_waiting : dbg_pkg::st_step;
      default:
        state_next = dbg_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= dbg_pkg::st_idle;
      step_fire_q <= 1'b0;
    end
    else
    begin
      state       <= state_next;
      step_fire_q <= step_hit;  // bucket is valid after the enabled cycle
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // enabled cycle counter
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      cycle_q <= '0;
    else if ((state == dbg_pkg::st_waiting) && byte_valid)
      cycle_q <= '0;  // any command leaves waiting
    else if (cpu_clk_en)
      cycle_q <= cycle_q + 1'b1;
  end

endmodule

// File: dbg_program_loader.sv
`include "dbg_params.svh"

module dbg_program_loader (
  input  logic                clk,
  input  logic                reset,
  input  logic                load_en,
  input  logic                byte_valid,
  input  dbg_pkg::byte_t      byte_data,
  output logic                inst_we,
  output dbg_pkg::inst_addr_t inst_addr,
  output dbg_pkg::inst_word_t inst_data,
  output logic                load_done
);

  localparam int word_bytes = `DBG_WORD_W / `DBG_BYTE_W;
  localparam int pos_w      = $clog2(word_bytes);
  localparam logic [pos_w-1:0] last_pos = pos_w'(word_bytes - 1);

  logic [pos_w-1:0]    pos_q;      // byte position inside the word
  dbg_pkg::inst_word_t word_q;     // assembly shift register
  dbg_pkg::inst_word_t word_next;
  logic                take_byte;
  logic                word_full;

  assign take_byte = load_en && byte_valid;
  assign word_full = take_byte && (pos_q == last_pos);

  // new byte enters at the top, so the first one ends up lowest
  assign word_next = {byte_data, word_q[`DBG_WORD_W-1:`DBG_BYTE_W]};

  assign inst_data = word_q;  // stable until the next byte arrives

  always_ff @(posedge clk)
  begin
    if (take_byte)
      word_q <= word_next;
  end

  //////////////////////////////////////////////////////////////////////////
  // position, write strobe and address
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pos_q     <= '0;
      inst_addr <= '0;
      inst_we   <= 1'b0;
      load_done <= 1'b0;
    end
    else
    begin
      inst_we   <= word_full;
      // end marker checked on the completed word
      load_done <= word_full && (&word_next[`DBG_WORD_W-1 -: `DBG_END_OPCODE_W]);
      if (!load_en)
      begin
        pos_q     <= '0;  // ready for a fresh program
        inst_addr <= '0;
      end
      else
      begin
        if (take_byte)
          pos_q <= pos_q + 1'b1;  // wraps after the last byte
        if (inst_we)
          inst_addr <= inst_addr + 1'b1;  // next word address
      end
    end
  end

endmodule

// File: dbg_rx_stage.sv
module dbg_rx_stage (
  input  logic           clk,
  input  logic           reset,
  input  logic           rx_done_tick,
  input  dbg_pkg::byte_t rx_data,
  output logic           byte_valid,
  output dbg_pkg::byte_t byte_data
);

  logic rx_done_q;  // previous sample of the receive-done level
  logic rx_rise;

  // first sample high after a low sample
  assign rx_rise = rx_done_tick & ~rx_done_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_done_q  <= 1'b0;
      byte_valid <= 1'b0;
    end
    else
    begin
      rx_done_q  <= rx_done_tick;
      byte_valid <= rx_rise;  // single strobe per received byte
    end
  end

  // byte captured together with the edge
  always_ff @(posedge clk)
  begin
    if (rx_rise)
      byte_data <= rx_data;
  end

endmodule

// File: dbg_pkg.sv
`include "dbg_params.svh"

package dbg_pkg;

  typedef logic [`DBG_BYTE_W-1:0]      byte_t;
  typedef logic [`DBG_WORD_W-1:0]      inst_word_t;
  typedef logic [`DBG_INST_ADDR_W-1:0] inst_addr_t;
  typedef logic [`DBG_WORD_W-1:0]      bucket_t;
  typedef logic [`DBG_CYCLE_W-1:0]     cycle_count_t;

  // run states of the debug unit
  typedef enum logic [2:0] {
    st_idle,
    st_programming,
    st_waiting,
    st_step,
    st_continuous,
    st_sending
  } dbg_state_e;

  // command bytes from the host
  typedef enum logic [`DBG_BYTE_W-1:0] {
    cmd_start      = `DBG_CMD_START,
    cmd_continuous = `DBG_CMD_CONTINUOUS,
    cmd_step_mode  = `DBG_CMD_STEP_MODE,
    cmd_reprogram  = `DBG_CMD_REPROGRAM,
    cmd_step       = `DBG_CMD_STEP
  } dbg_cmd_e;

endpackage

// File: dbg_params.svh
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// datapath widths
`define DBG_BYTE_W        8
`define DBG_WORD_W        32
`define DBG_BUCKET_BYTES  4   // bytes sent per bucket snapshot
`define DBG_INST_ADDR_W   7
`define DBG_CYCLE_W       32
`define DBG_END_OPCODE_W  6   // top bits all ones mark the last program word

// host command codes
`define DBG_CMD_START       8'h01
`define DBG_CMD_CONTINUOUS  8'h02
`define DBG_CMD_STEP_MODE   8'h03
`define DBG_CMD_REPROGRAM   8'h05
`define DBG_CMD_STEP        8'h06

`endif
